// ==== dv/loader_tests.txt ====
# B hh stream byte, C close and drain, L v expected loading after a close
# W aaaaaa dddd expected memory write (word address, data) in stream order
L 0
B 01
B 01
B 02
B 06
B 11
B 22
B 33
B 44
W 008103 2211
W 008104 4433
C
L 1
B 01
B 00
B 10
B 21
B AA
B BB
B CC
W 000810 AA00
W 000811 CCBB
C
B 07
B 00
B 00
B 00
B 55
B 66
C
L 1
B 02
C
L 0
B 01
B 3F
B FF
B FE
C
B 01
B 7F
B 00
B 04
B 01
B 02
B 03
W 3F8002 0201
C
B 01
B 12
B 34
B 56
B A0
B A1
B A2
B A3
B A4
B A5
B A6
B A7
B A8
B A9
B AA
B AB
B AC
B AD
W 091A2B A1A0
W 091A2C A3A2
W 091A2D A5A4
W 091A2E A7A6
W 091A2F A9A8
W 091A30 ABAA
W 091A31 ADAC
C
L 1

// ==== dv/tb_byte_loader.sv ====
`timescale 1ns/1ps

module tb_byte_loader
    import loader_pkg::*;
();
    logic      clk;
    logic      reset;
    byte_t     in_data;
    logic      in_valid;
    logic      in_ready;
    logic      in_closed;
    logic      mem_req;
    mem_addr_t mem_addr;
    mem_word_t mem_wdata;
    logic      mem_ready;
    logic      loading;

    // stream operations in file order and expected writes in queues of their own
    logic [7:0] op_kind [$];
    int         op_arg [$];
    int         exp_addr [$];
    int         exp_data [$];

    logic [31:0] lfsr;
    logic        ready_next;
    logic        saw_full;
    logic        tests_ok;
    int          stall_left;
    int          errors;
    int          writes_seen;
    int          cycles;
    int          cycle_limit;

    byte_loader_top uut (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_closed (in_closed),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .loading   (loading)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic int next_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic finish_run();
        $display("writes checked %0d, writes still expected %0d, errors %0d",
                 writes_seen, exp_addr.size(), errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic read_tests(output logic ok);
        int            fd;
        int            rc;
        int            a;
        int            d;
        logic [7:0]    kind;
        logic [1023:0] rest;
        ok = 1'b0;
        fd = $fopen("dv/loader_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            rc = $fscanf(fd, " %c", kind);
            while (rc == 1) begin
                case (kind)
                    "#": rc = $fgets(rest, fd);
                    "W": begin
                        rc = $fscanf(fd, " %h %h", a, d);
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                    end
                    "B", "L": begin
                        rc = $fscanf(fd, " %h", a);
                        op_kind.push_back(kind);
                        op_arg.push_back(a);
                    end
                    "C": begin
                        op_kind.push_back(kind);
                        op_arg.push_back(0);
                    end
                    default: begin
                        ok = 1'b0;
                        $display("tests file has a line of unknown kind %c", kind);
                    end
                endcase
                rc = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
    endtask

    // entered and left just after a rising edge
    task automatic send_byte(input byte_t b);
        logic accepted;
        while (next_bits(3) == 0) begin
            in_valid <= 1'b0;    // idle cycle
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= b;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
        end
    endtask

    task automatic close_stream();
        logic drained;
        in_valid  <= 1'b0;
        in_closed <= 1'b1;
        drained = 1'b0;
        while (!drained) begin
            @(negedge clk);
            drained = uut.rd_empty;
            @(posedge clk);
        end
        in_closed <= 1'b0;    // close taken on this edge
    endtask

    task automatic expect_loading(input int v);
        in_valid <= 1'b0;
        @(negedge clk);
        check_value("loading", 32'(loading), 32'(v));
        @(posedge clk);
    endtask

    task automatic run_tests();
        int i;
        int drain;
        cycle_limit = 40 * (op_kind.size() + exp_addr.size()) + 200;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < op_kind.size(); i++) begin
            case (op_kind[i])
                "B":     send_byte(byte_t'(op_arg[i]));
                "C":     close_stream();
                default: expect_loading(op_arg[i]);
            endcase
        end
        in_valid <= 1'b0;
        drain = 0;
        while (exp_addr.size() != 0 && drain < 600) begin
            @(posedge clk);
            drain++;
        end
        repeat (50) @(posedge clk);    // room for stray writes
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%0d expected memory writes never appeared", exp_addr.size());
        end
        if (!saw_full) begin
            errors++;
            $display("the input FIFO never filled, in_ready stayed high all run");
        end
    endtask

    initial begin
        reset       = 1'b1;
        in_data     = '0;
        in_valid    = 1'b0;
        in_closed   = 1'b0;
        mem_ready   = 1'b0;
        ready_next  = 1'b0;
        stall_left  = 0;
        lfsr        = 32'd75302;
        saw_full    = 1'b0;
        errors      = 0;
        writes_seen = 0;
        cycles      = 0;
        cycle_limit = 200;
        read_tests(tests_ok);
        if (tests_ok) begin
            run_tests();
        end else begin
            errors++;
            $display("could not read the tests file dv/loader_tests.txt");
        end
        finish_run();
    end

    // memory side with long random stalls
    always @(negedge clk) begin
        if (reset) begin
            stall_left = 0;
            ready_next = 1'b0;
        end else if (stall_left != 0) begin
            stall_left = stall_left - 1;
            ready_next = 1'b0;
        end else if (next_bit() == 1'b0) begin
            stall_left = 16 + next_bits(4);
            ready_next = 1'b0;
        end else begin
            ready_next = 1'b1;
        end
    end

    always @(posedge clk) begin
        mem_ready <= ready_next;
    end

    // a write completes on the edge after this sample
    always @(negedge clk) begin
        if (!reset) begin
            if (!in_ready) begin
                saw_full = 1'b1;
            end
            if (mem_req && mem_ready) begin
                writes_seen++;
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("unexpected memory write at %0t ns to address %h",
                             $time, mem_addr);
                end else begin
                    check_value("mem_addr", 32'(mem_addr), exp_addr.pop_front());
                    check_value("mem_wdata", 32'(mem_wdata), exp_data.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            errors++;
            $display("timeout after %0d cycles, the run did not finish", cycles);
            finish_run();
        end
    end

endmodule

// ==== rtl/addr_counter.sv ====
`timescale 1ns/1ps

module addr_counter
    import loader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      addr_load,
    input  mem_addr_t addr_load_value,
    input  logic      addr_step,
    output mem_addr_t addr
);
    mem_addr_t addr_reg;    // loaded address, then the last one handed out
    logic      first_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            first_word <= 1'b0;
        end else if (addr_load) begin
            first_word <= 1'b1;
        end else if (addr_step) begin
            first_word <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_load) begin
            addr_reg <= addr_load_value;
        end else if (addr_step && !first_word) begin
            addr_reg <= addr_reg + 1'b1;
        end
    end

    // first word lands on the loaded address itself
    assign addr = first_word ? addr_reg : addr_reg + 1'b1;

endmodule

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

module byte_fifo (
    input  logic               clk,
    input  logic               reset,
    input  loader_pkg::byte_t  in_data,
    input  logic               in_valid,
    output logic               in_ready,
    output loader_pkg::byte_t  rd_data,
    input  logic               rd_en,
    output logic               rd_empty
);
    localparam int DEPTH = `LOADER_FIFO_DEPTH;
    localparam int PTR_W = `LOADER_FIFO_PTR_W;

    loader_pkg::byte_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign in_ready = (count != (PTR_W + 1)'(DEPTH));
    assign rd_empty = (count == '0);
    assign rd_data  = mem[rd_ptr];    // head entry

    assign do_wr = in_valid && in_ready;
    assign do_rd = rd_en && !rd_empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

// ==== rtl/byte_loader_top.sv ====
`timescale 1ns/1ps

module byte_loader_top
    import loader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  byte_t     in_data,
    input  logic      in_valid,
    output logic      in_ready,
    input  logic      in_closed,
    output logic      mem_req,
    output mem_addr_t mem_addr,
    output mem_word_t mem_wdata,
    input  logic      mem_ready,
    output logic      loading
);
    byte_t     rd_data;
    logic      rd_empty;
    logic      rd_en;
    logic      addr_load;
    mem_addr_t addr_load_value;
    logic      addr_step;
    mem_addr_t addr;
    logic      word_push;
    mem_word_t word_data;
    logic      word_full;

    byte_fifo u_fifo (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .rd_data  (rd_data),
        .rd_en    (rd_en),
        .rd_empty (rd_empty)
    );

    loader_fsm u_fsm (
        .clk             (clk),
        .reset           (reset),
        .rd_data         (rd_data),
        .rd_empty        (rd_empty),
        .rd_en           (rd_en),
        .in_closed       (in_closed),
        .addr_load       (addr_load),
        .addr_load_value (addr_load_value),
        .addr_step       (addr_step),
        .word_push       (word_push),
        .word_data       (word_data),
        .word_full       (word_full),
        .loading         (loading)
    );

    addr_counter u_addr (
        .clk             (clk),
        .reset           (reset),
        .addr_load       (addr_load),
        .addr_load_value (addr_load_value),
        .addr_step       (addr_step),
        .addr            (addr)
    );

    word_writer u_writer (
        .clk       (clk),
        .reset     (reset),
        .word_push (word_push),
        .word_data (word_data),
        .addr      (addr),
        .word_full (word_full),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready)
    );

endmodule

// ==== rtl/loader_defs.svh ====
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// memory word address width
`define LOADER_ADDR_W 22

// input byte fifo
`define LOADER_FIFO_DEPTH 8
`define LOADER_FIFO_PTR_W 3

`endif

// ==== rtl/loader_fsm.sv ====
`timescale 1ns/1ps
`include "loader_defs.svh"

module loader_fsm
    import loader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  byte_t     rd_data,
    input  logic      rd_empty,
    output logic      rd_en,
    input  logic      in_closed,
    output logic      addr_load,
    output mem_addr_t addr_load_value,
    output logic      addr_step,
    output logic      word_push,
    output mem_word_t word_data,
    input  logic      word_full,
    output logic      loading
);
    loader_state_t state;
    cmd_code_t     cmd;

    logic [1:0]                byte_cnt;
    logic [`LOADER_ADDR_W-8:0] addr_hi;     // address bits 21..7
    logic                      high_phase;  // next data byte is the high byte
    byte_t                     low_byte;

    // read and push decisions are made in the same cycle as the byte
    always_comb begin
        rd_en     = 1'b0;
        word_push = 1'b0;
        addr_load = 1'b0;
        if (!rd_empty) begin
            case (state)
                ST_CMD: begin
                    rd_en = 1'b1;
                end
                ST_ADDR: begin
                    rd_en     = 1'b1;
                    addr_load = (byte_cnt == 2'd2);
                end
                ST_DATA: begin
                    if (cmd == CMD_WRITE && high_phase) begin
                        // hold the high byte until the writer has room
                        if (!word_full) begin
                            rd_en     = 1'b1;
                            word_push = 1'b1;
                        end
                    end else begin
                        rd_en = 1'b1;
                    end
                end
                default: begin
                    rd_en = 1'b0;
                end
            endcase
        end
    end

    assign addr_step       = word_push;
    assign addr_load_value = {addr_hi, rd_data[7:1]};
    assign word_data       = {rd_data, low_byte};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_CMD;
            loading  <= 1'b0;
            byte_cnt <= 2'd0;
        end else if (in_closed && rd_empty) begin
            state <= ST_CMD;    // stream closed so the command is dropped
        end else if (rd_en) begin
            case (state)
                ST_CMD: begin
                    cmd      <= cmd_code_t'(rd_data);
                    byte_cnt <= 2'd0;
                    if (cmd_code_t'(rd_data) == CMD_END) begin
                        loading <= 1'b0;
                    end else begin
                        state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    case (byte_cnt)
                        2'd0: addr_hi[14:8] <= rd_data[6:0];
                        2'd1: addr_hi[7:0]  <= rd_data;
                        default: begin
                            high_phase <= rd_data[0];
                            low_byte   <= '0;
                            state      <= ST_DATA;
                        end
                    endcase
                    byte_cnt <= byte_cnt + 2'd1;
                end
                ST_DATA: begin
                    if (cmd == CMD_WRITE) begin
                        loading <= 1'b1;
                        if (!high_phase) begin
                            low_byte <= rd_data;
                        end
                        high_phase <= !high_phase;
                    end
                    // other codes just drain their data
                end
                default: begin
                    state <= ST_CMD;
                end
            endcase
        end
    end

endmodule

// ==== rtl/loader_pkg.sv ====
`include "loader_defs.svh"

package loader_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] mem_word_t;
    typedef logic [`LOADER_ADDR_W-1:0] mem_addr_t;

    // any other code parses an address and drops its data
    typedef enum logic [7:0] {
        CMD_WRITE = 8'd1,
        CMD_END   = 8'd2
    } cmd_code_t;

    typedef enum logic [1:0] {
        ST_CMD,
        ST_ADDR,
        ST_DATA
    } loader_state_t;

endpackage

// ==== rtl/word_writer.sv ====
`timescale 1ns/1ps

module word_writer
    import loader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      word_push,
    input  mem_word_t word_data,
    input  mem_addr_t addr,
    output logic      word_full,
    output logic      mem_req,
    output mem_addr_t mem_addr,
    output mem_word_t mem_wdata,
    input  logic      mem_ready
);
    // a push may land on the completing edge
    assign word_full = mem_req && !mem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req <= 1'b0;
        end else if (word_push) begin
            mem_req <= 1'b1;
        end else if (mem_ready) begin
            mem_req <= 1'b0;
        end
    end

    // addr is sampled before the counter steps on this edge
    always_ff @(posedge clk) begin
        if (word_push) begin
            mem_addr  <= addr;
            mem_wdata <= word_data;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the byte loader testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary -f sim.f --top-module tb_byte_loader \
    --Mdir "$build_dir" -o tb_byte_loader
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_byte_loader" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== sim.f ====
+incdir+rtl
rtl/loader_pkg.sv
rtl/byte_fifo.sv
rtl/loader_fsm.sv
rtl/addr_counter.sv
rtl/word_writer.sv
rtl/byte_loader_top.sv
dv/tb_byte_loader.sv
